// ==== logic/cr_pkg.sv ====
/*
	Clock recovery shared definitions
	Data path widths, saturation limits and the bus structs
*/
package cr_pkg;

	// Data path widths
	localparam int ERR_W   = 6;		// Signed window error
	localparam int SUM_W   = 15;	// Signed integrator
	localparam int PGAIN_W = 8;		// Unsigned P gain
	localparam int IGAIN_W = 13;	// Unsigned I gain
	localparam int CO_W    = 29;	// Signed controller output
	localparam int WORD_W  = 32;	// Output word to the DIA port

	// Video parameter set
	localparam int HTOTAL_IDX = 4;	// Slot of the htotal register

	// Scalar types
	typedef logic signed [ERR_W-1:0] err_t;
	typedef logic signed [SUM_W-1:0] sum_t;
	typedef logic signed [CO_W-1:0]  co_t;
	typedef logic [WORD_W-1:0]       word_t;	// co zero-extended, top bits zero

	// Error saturation, +31 and -32
	localparam err_t ERR_MAX = err_t'(2**(ERR_W-1) - 1);
	localparam err_t ERR_MIN = err_t'(-(2**(ERR_W-1)));

	// Integrator saturation, +16383 and -16384
	localparam sum_t SUM_MAX = sum_t'(2**(SUM_W-1) - 1);
	localparam sum_t SUM_MIN = sum_t'(-(2**(SUM_W-1)));

	// Video parameter set write port
	typedef struct packed {
		logic [3:0]  idx;	// Register index
		logic [15:0] dat;	// Write data
		logic        vld;	// Write strobe
	} vps_t;

	// Loop gains
	typedef struct packed {
		logic [PGAIN_W-1:0] p_gain;
		logic [IGAIN_W-1:0] i_gain;
	} gains_t;

	// Loop statistics and state
	// Errors are signed, extremes start from zero
	typedef struct packed {
		err_t cur_err;	// Last accepted error
		err_t max_err;	// Largest error since run
		err_t min_err;	// Smallest error since run
		sum_t sum;		// Integrator
		co_t  co;		// Controller output
	} status_t;

endpackage

// ==== logic/req_ack_slot.sv ====
/*
	Four-phase req/ack slot
	Holds one payload and offers it until the receiver has acknowledged
*/
`timescale 1ns/1ns

module req_ack_slot
#(
	parameter type T_PAYLOAD = logic	// Carried payload
)
(
	input  logic     SYS_CLK_IN,
	input  logic     arst_n,
	input  logic     run,			// Low empties the slot
	input  logic     load,			// Capture strobe
	input  T_PAYLOAD payload_in,
	output logic     req,
	input  logic     ack,
	output T_PAYLOAD payload,
	output logic     free			// Ready for the next load
);

	typedef enum logic [1:0] {
		SL_EMPTY,
		SL_OFFER,
		SL_DRAIN
	} slot_state_t;

	slot_state_t state;

	// Payload capture, held through offer and drain
	always_ff @(posedge SYS_CLK_IN)
	begin
		if (load && (state == SL_EMPTY))
			payload <= payload_in;
	end

	// Handshake sequencer
	always_ff @(posedge SYS_CLK_IN or negedge arst_n)
	begin
		if (!arst_n)
			state <= SL_EMPTY;
		else if (!run)
			state <= SL_EMPTY;
		else
		begin
			case (state)
				SL_EMPTY :
					if (load)
						state <= SL_OFFER;	// req next cycle
				SL_OFFER :
					if (ack)
						state <= SL_DRAIN;	// Drop req
				SL_DRAIN :
					if (!ack)
						state <= SL_EMPTY;	// Return to zero done
				default :
					state <= SL_EMPTY;
			endcase
		end
	end

	assign req  = (state == SL_OFFER);
	assign free = (state == SL_EMPTY);

endmodule

// ==== logic/phase_meter.sv ====
/*
	Phase meter
	Counts pixel strobes against a window of sync edges, gives a saturating error
*/
`timescale 1ns/1ns

module phase_meter
	import cr_pkg::*;
#(
	parameter int P_LINES = 256,	// Sync edges per window
	parameter int P_PPC   = 2		// Pixels per strobe
)
(
	input  logic  SYS_CLK_IN,
	input  logic  arst_n,
	input  logic  run,			// Measurement enable
	input  vps_t  vps,			// Parameter set writes
	input  logic  sync,			// Sync level
	input  logic  pix_en,		// Pixel strobe
	input  logic  slot_free,	// Error slot empty
	output logic  load,			// Error ready pulse
	output err_t  err			// Window error
);

	localparam int SYNC_W = $clog2(P_LINES + 1);
	localparam int PIX_W  = 16 + SYNC_W;	// htotal times P_LINES

	typedef enum logic [1:0] {
		PM_IDLE,
		PM_RUN,
		PM_WAIT
	} pm_state_t;

	pm_state_t         state;
	logic [15:0]       htotal;
	logic              sync_q;
	logic              sync_rise;
	logic              sync_edge;
	logic [SYNC_W-1:0] sync_cnt;
	logic [PIX_W-1:0]  pix_cnt;
	logic              sync_end;
	logic              pix_end;
	logic              start;
	logic              done;
	err_t              err_cnt;

	// Htotal register
	always_ff @(posedge SYS_CLK_IN or negedge arst_n)
	begin
		if (!arst_n)
			htotal <= '0;
		else if (vps.vld && (vps.idx == 4'(HTOTAL_IDX)))
			htotal <= vps.dat;
	end

	// Sync capture, one stage
	always_ff @(posedge SYS_CLK_IN or negedge arst_n)
	begin
		if (!arst_n)
			sync_q <= 1'b0;
		else
			sync_q <= sync;
	end

	assign sync_rise = sync & ~sync_q;	// Window start
	assign sync_edge = sync ^ sync_q;	// Both edges count
	assign sync_end  = (sync_cnt == '0);
	assign pix_end   = (pix_cnt == '0);

	// Window start and end
	assign start = run && (state == PM_IDLE) && sync_rise;
	assign done  = run && (state == PM_RUN) && sync_end && pix_end;

	// Window FSM
	always_ff @(posedge SYS_CLK_IN or negedge arst_n)
	begin
		if (!arst_n)
			state <= PM_IDLE;
		else if (!run)
			state <= PM_IDLE;
		else
		begin
			case (state)
				PM_IDLE :
					if (sync_rise)
						state <= PM_RUN;
				PM_RUN :
					if (sync_end && pix_end)
						state <= PM_WAIT;
				// Slot still shows free during the load cycle
				PM_WAIT :
					if (slot_free && !load)
						state <= PM_IDLE;
				default :
					state <= PM_IDLE;
			endcase
		end
	end

	// Error ready, one cycle after both counters end
	always_ff @(posedge SYS_CLK_IN or negedge arst_n)
	begin
		if (!arst_n)
			load <= 1'b0;
		else
			load <= done;
	end

	// Sync counter
	always_ff @(posedge SYS_CLK_IN or negedge arst_n)
	begin
		if (!arst_n)
			sync_cnt <= '0;
		else if (start)
			sync_cnt <= SYNC_W'(P_LINES);
		else if ((state == PM_RUN) && sync_edge && !sync_end)
			sync_cnt <= sync_cnt - 1'b1;	// Rising and falling
	end

	// Pixel counter
	always_ff @(posedge SYS_CLK_IN or negedge arst_n)
	begin
		if (!arst_n)
			pix_cnt <= '0;
		else if (start)
			pix_cnt <= PIX_W'(htotal) * PIX_W'(P_LINES);
		else if ((state == PM_RUN) && pix_en && !pix_end)
		begin
			if (pix_cnt > PIX_W'(P_PPC))
				pix_cnt <= pix_cnt - PIX_W'(P_PPC);
			else
				pix_cnt <= '0;	// Stops at zero
		end
	end

	// Error counter
	always_ff @(posedge SYS_CLK_IN or negedge arst_n)
	begin
		if (!arst_n)
			err_cnt <= '0;
		else if (start)
			err_cnt <= '0;
		else if ((state == PM_RUN) && pix_en)
		begin
			// Video slow, pixels still due after sync end
			if (sync_end && !pix_end && (err_cnt != ERR_MAX))
				err_cnt <= err_cnt + err_t'(1);
			// Video fast, pixels done before sync end
			else if (!sync_end && pix_end && (err_cnt != ERR_MIN))
				err_cnt <= err_cnt - err_t'(1);
		end
	end

	assign err = err_cnt;

endmodule

// ==== logic/pi_controller.sv ====
/*
	PI controller
	Integrates window errors, forms the controller output and keeps error statistics
*/
`timescale 1ns/1ns

module pi_controller
	import cr_pkg::*;
(
	input  logic    SYS_CLK_IN,
	input  logic    arst_n,
	input  logic    run,		// Low clears loop state
	input  gains_t  gains,
	input  err_t    err,		// From the error slot
	input  logic    err_req,
	output logic    err_ack,
	input  logic    out_free,	// Output slot empty
	output logic    out_load,
	output word_t   out_word,
	output status_t status
);

	localparam int P_W = ERR_W + PGAIN_W + 1;	// Signed P product
	localparam int I_W = SUM_W + IGAIN_W + 1;	// Signed I product

	typedef enum logic [1:0] {
		CS_IDLE,	// Wait for an error
		CS_SUM,		// Sum valid, products next
		CS_PROD,	// Products valid, co next
		CS_LOAD		// co valid, hand to output slot
	} cs_state_t;

	cs_state_t              state;
	logic                   accept;
	logic signed [SUM_W:0]  sum_ext;	// One guard bit
	sum_t                   sum_sat;
	sum_t                   sum;
	err_t                   cur_err;
	err_t                   max_err;
	err_t                   min_err;
	logic signed [P_W-1:0]  p;
	logic signed [I_W-1:0]  i;
	co_t                    co;

	// One error at a time, only with room downstream
	assign accept = (state == CS_IDLE) && err_req && !err_ack && out_free;

	// Sequencer
	always_ff @(posedge SYS_CLK_IN or negedge arst_n)
	begin
		if (!arst_n)
			state <= CS_IDLE;
		else if (!run)
			state <= CS_IDLE;
		else
		begin
			case (state)
				CS_IDLE :
					if (accept)
						state <= CS_SUM;
				CS_SUM  : state <= CS_PROD;
				CS_PROD : state <= CS_LOAD;
				CS_LOAD : state <= CS_IDLE;
				default : state <= CS_IDLE;
			endcase
		end
	end

	assign out_load = (state == CS_LOAD);

	// Acknowledge, up on accept, down after req falls
	always_ff @(posedge SYS_CLK_IN or negedge arst_n)
	begin
		if (!arst_n)
			err_ack <= 1'b0;
		else if (!run)
			err_ack <= 1'b0;
		else if (accept)
			err_ack <= 1'b1;
		else if (!err_req)
			err_ack <= 1'b0;
	end

	// Integrator with saturation
	assign sum_ext = sum + err;
	always_comb
	begin
		if (sum_ext > SUM_MAX)
			sum_sat = SUM_MAX;
		else if (sum_ext < SUM_MIN)
			sum_sat = SUM_MIN;
		else
			sum_sat = sum_t'(sum_ext);
	end

	// Sum and statistics, one cycle after accept
	always_ff @(posedge SYS_CLK_IN or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sum     <= '0;
			cur_err <= '0;
			max_err <= '0;
			min_err <= '0;
		end
		else if (!run)
		begin
			sum     <= '0;
			cur_err <= '0;
			max_err <= '0;	// Extremes restart from zero
			min_err <= '0;
		end
		else if (accept)
		begin
			sum     <= sum_sat;
			cur_err <= err;
			if (err > max_err)
				max_err <= err;
			if (err < min_err)
				min_err <= err;
		end
	end

	// P and I products, gains taken as unsigned
	always_ff @(posedge SYS_CLK_IN)
	begin
		if (state == CS_SUM)
		begin
			p <= $signed({1'b0, gains.p_gain}) * cur_err;
			i <= $signed({1'b0, gains.i_gain}) * sum;	// New sum
		end
	end

	// Controller output
	always_ff @(posedge SYS_CLK_IN or negedge arst_n)
	begin
		if (!arst_n)
			co <= '0;
		else if (!run)
			co <= '0;
		else if (state == CS_PROD)
			co <= p + i;
	end

	assign out_word = {{(WORD_W-CO_W){1'b0}}, co};	// Zero-extended

	assign status = '{
		cur_err : cur_err,
		max_err : max_err,
		min_err : min_err,
		sum     : sum,
		co      : co
	};

endmodule

// ==== logic/clock_recovery_top.sv ====
/*
	Clock recovery loop top level
	Phase meter, error slot, PI controller and output word slot in one chain
*/
`timescale 1ns/1ns

module clock_recovery_top
	import cr_pkg::*;
#(
	parameter int P_LINES = 256,	// Sync edges per window
	parameter int P_PPC   = 2		// Pixels per strobe
)
(
	input  logic    SYS_CLK_IN,
	input  logic    arst_n,
	input  logic    run,
	input  vps_t    vps,		// Video parameter set
	input  logic    sync,
	input  logic    pix_en,
	input  gains_t  gains,
	output status_t status,
	output word_t   dia_dat,	// DIA output word
	output logic    dia_req,
	input  logic    dia_ack
);

	// Meter to error slot
	logic  meas_load;
	err_t  meas_err;
	logic  meas_free;

	// Error slot to controller
	logic  meas_req;
	logic  meas_ack;
	err_t  meas_pay;

	// Controller to output slot
	logic  out_load;
	word_t out_word;
	logic  out_free;

	phase_meter #(
		.P_LINES (P_LINES),
		.P_PPC   (P_PPC)
	) meter (
		.SYS_CLK_IN (SYS_CLK_IN),
		.arst_n     (arst_n),
		.run        (run),
		.vps        (vps),
		.sync       (sync),
		.pix_en     (pix_en),
		.slot_free  (meas_free),
		.load       (meas_load),
		.err        (meas_err)
	);

	// Error hand-over
	req_ack_slot #(
		.T_PAYLOAD (err_t)
	) meas_slot (
		.SYS_CLK_IN (SYS_CLK_IN),
		.arst_n     (arst_n),
		.run        (run),
		.load       (meas_load),
		.payload_in (meas_err),
		.req        (meas_req),
		.ack        (meas_ack),
		.payload    (meas_pay),
		.free       (meas_free)
	);

	pi_controller ctrl (
		.SYS_CLK_IN (SYS_CLK_IN),
		.arst_n     (arst_n),
		.run        (run),
		.gains      (gains),
		.err        (meas_pay),
		.err_req    (meas_req),
		.err_ack    (meas_ack),
		.out_free   (out_free),
		.out_load   (out_load),
		.out_word   (out_word),
		.status     (status)
	);

	// Output word to the DIA port
	req_ack_slot #(
		.T_PAYLOAD (word_t)
	) out_slot (
		.SYS_CLK_IN (SYS_CLK_IN),
		.arst_n     (arst_n),
		.run        (run),
		.load       (out_load),
		.payload_in (out_word),
		.req        (dia_req),
		.ack        (dia_ack),
		.payload    (dia_dat),
		.free       (out_free)
	);

endmodule

// ==== bench/cr_model.svh ====
/*
	Clock recovery reference model
	Window error from the driven sync and strobes, integrator, controller output and statistics
*/
`ifndef CR_MODEL_SVH
`define CR_MODEL_SVH

localparam int M_IDLE = 0;	// Waiting for a sync rise
localparam int M_RUN  = 1;	// Window open
localparam int M_DONE = 2;	// Error known

localparam int E_HI = 31;		// Error limits
localparam int E_LO = -32;
localparam int S_HI = 16383;	// Integrator limits
localparam int S_LO = -16384;

int    m_state;
logic  m_sync_prev = 1'b0;	// Sync level seen last clock
int    m_sync_rem;			// Sync edges still due
int    m_pix_rem;			// Pixels still due
int    m_err;				// Window error so far
int    m_sum;
int    m_cur;
int    m_max;
int    m_min;
int    m_co;
word_t m_word;

function automatic int clamp(input int value, input int lo, input int hi);
	if (value > hi)
		return hi;
	else if (value < lo)
		return lo;
	return value;
endfunction

// One clock of the window rule on the sampled inputs
task automatic track_window(input logic run_s, input logic sync_s, input logic pix_s);
	logic edge_seen;
	edge_seen = (sync_s != m_sync_prev);
	if (!run_s)
		m_state = M_IDLE;
	else if ((m_state == M_IDLE) && sync_s && !m_sync_prev)
	begin
		m_state    = M_RUN;	// Rising edge opens the window
		m_sync_rem = P_LINES;
		m_pix_rem  = htotal_val * P_LINES;
		m_err      = 0;
	end
	else if (m_state == M_RUN)
	begin
		if ((m_sync_rem == 0) && (m_pix_rem == 0))
			m_state = M_DONE;
		else
		begin
			if (pix_s && (m_sync_rem == 0))
				m_err = clamp(m_err + 1, E_LO, E_HI);	// Slow, pixels still due
			else if (pix_s && (m_pix_rem == 0))
				m_err = clamp(m_err - 1, E_LO, E_HI);	// Fast, lines still due
			if (pix_s)
				m_pix_rem = (m_pix_rem > P_PPC) ? m_pix_rem - P_PPC : 0;
			if (edge_seen && (m_sync_rem > 0))
				m_sync_rem--;	// Both edges count
		end
	end
	m_sync_prev = sync_s;
endtask

// PI step on one accepted error
task automatic integrate_error(input int e, input gains_t g);
	m_sum = clamp(m_sum + e, S_LO, S_HI);
	m_cur = e;
	if (e > m_max)
		m_max = e;
	if (e < m_min)
		m_min = e;
	m_co   = int'(g.p_gain) * e + int'(g.i_gain) * m_sum;	// Gains unsigned
	m_word = word_t'(m_co[28:0]);	// Zero-extended 29 bits
endtask

// Loop state after reset or run low
task automatic clear_model;
	m_state = M_IDLE;
	m_err   = 0;
	m_sum   = 0;
	m_cur   = 0;
	m_max   = 0;	// Extremes start from zero
	m_min   = 0;
	m_co    = 0;
	m_word  = '0;
endtask

`endif

// ==== bench/tb_clock_recovery.sv ====
/*
	Clock recovery loop testbench
	Seeded random sync and pixel strobes checked against a cycle model, DIA acknowledge
*/
`timescale 1ns/1ns

module tb_clock_recovery
	import cr_pkg::*;
();

	localparam int P_LINES = 8;	// Short windows
	localparam int P_PPC   = 2;

	logic    SYS_CLK_IN = 1'b0;
	logic    arst_n;
	logic    run;
	vps_t    vps;
	logic    sync;
	logic    pix_en;
	gains_t  gains;
	status_t status;
	word_t   dia_dat;
	logic    dia_req;
	logic    dia_ack;

	int          htotal_val;	// Last htotal written
	int          errors;
	int          checks;
	int          tests_ok;
	int          err_mark;		// Errors at test start

	`include "cr_model.svh"

	clock_recovery_top #(
		.P_LINES (P_LINES),
		.P_PPC   (P_PPC)
	) dut0 (
		.SYS_CLK_IN (SYS_CLK_IN),
		.arst_n     (arst_n),
		.run        (run),
		.vps        (vps),
		.sync       (sync),
		.pix_en     (pix_en),
		.gains      (gains),
		.status     (status),
		.dia_dat    (dia_dat),
		.dia_req    (dia_req),
		.dia_ack    (dia_ack)
	);

	always #5 SYS_CLK_IN = ~SYS_CLK_IN;	// 10 ns period

	// Rising edge, model sees what the DUT samples
	task automatic tick;
		@(posedge SYS_CLK_IN);
		track_window(run, sync, pix_en);
	endtask

	task automatic compare(input string name, input logic signed [63:0] exp,
		input logic signed [63:0] got);
		checks++;
		if (got !== exp)
		begin
			$display("MISMATCH at %0t ns: %s expected %0d, got %0d", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic write_htotal(input int value);
		vps <= '{idx: 4'(HTOTAL_IDX), dat: 16'(value), vld: 1'b1};
		tick();
		vps <= '{idx: 4'd3, dat: 16'hFFFF, vld: 1'b1};	// Other index, ignored
		tick();
		vps <= '0;
		tick();
		htotal_val = value;
	endtask

	// One window, strobe density in percent, sync half period hp_min..hp_min+hp_span
	task automatic run_window(input int dens, input int hp_min, input int hp_span);
		logic lvl;
		int   edges;
		int   hold;
		int   guard;
		m_state = M_IDLE;
		sync    <= 1'b0;	// Fall ignored in idle
		pix_en  <= 1'b0;
		tick();
		tick();
		lvl   = 1'b1;
		sync  <= lvl;		// Window start
		edges = 0;
		hold  = hp_min + $urandom_range(hp_span);
		guard = 0;
		while ((m_state != M_DONE) && (guard < 4000))
		begin
			tick();
			pix_en <= ($urandom_range(99) < dens);
			hold--;
			if ((hold <= 0) && (edges < P_LINES))
			begin
				lvl   = ~lvl;
				sync  <= lvl;
				edges++;
				hold  = hp_min + $urandom_range(hp_span);
			end
			guard++;
		end
		pix_en <= 1'b0;
		if (m_state != M_DONE)
		begin
			$display("Window did not close within 4000 cycles at %0t ns", $time);
			errors++;
		end
	endtask

	// Takes one DIA word with a late acknowledge, checks word, status and handshake
	task automatic collect_word;
		word_t held;
		int    cnt;
		int    delay;
		cnt = 0;
		while (!dia_req && (cnt < 100))
		begin
			tick();
			cnt++;
		end
		if (!dia_req)
		begin
			$display("No output word offered within 100 cycles at %0t ns", $time);
			errors++;
		end
		else
		begin
			held = dia_dat;
			compare("dia_dat", m_word, dia_dat);
			compare("status.cur_err", m_cur, status.cur_err);
			compare("status.max_err", m_max, status.max_err);
			compare("status.min_err", m_min, status.min_err);
			compare("status.sum", m_sum, status.sum);
			compare("status.co", m_co, status.co);
			delay = $urandom_range(6);
			cnt   = 0;
			while (cnt < delay)
			begin
				tick();
				if (!dia_req)
				begin
					$display("dia_req fell before dia_ack rose at %0t ns", $time);
					errors++;
				end
				compare("dia_dat held", held, dia_dat);
				cnt++;
			end
			dia_ack <= 1'b1;
			tick();
			cnt = 0;
			while (dia_req && (cnt < 20))
			begin
				compare("dia_dat held", held, dia_dat);	// Stable while offered
				tick();
				cnt++;
			end
			if (dia_req)
			begin
				$display("dia_req stayed high after dia_ack at %0t ns", $time);
				errors++;
			end
			dia_ack <= 1'b0;
			tick();
		end
	endtask

	// New gains, one window, its word
	task automatic window_cycle(input int dens, input int hp_min, input int hp_span);
		gains <= 21'($urandom);
		run_window(dens, hp_min, hp_span);
		if (m_state == M_DONE)
		begin
			integrate_error(m_err, gains);
			collect_word();
		end
	endtask

	task automatic restart_run;
		run <= 1'b0;
		tick();
		tick();
		tick();
		run <= 1'b1;
		tick();
		clear_model();
	endtask

	task automatic report_test(input int num, input string name);
		if (errors == err_mark)
		begin
			$display("test %0d %s: ok", num, name);
			tests_ok++;
		end
		else
			$display("test %0d %s: %0d errors", num, name, errors - err_mark);
		err_mark = errors;
	endtask

	initial
	begin
		int k;
		int cnt;
		void'($urandom(95264));
		errors     = 0;
		checks     = 0;
		tests_ok   = 0;
		err_mark   = 0;
		htotal_val = 0;
		clear_model();
		arst_n  <= 1'b0;
		run     <= 1'b0;
		vps     <= '0;
		sync    <= 1'b0;
		pix_en  <= 1'b0;
		gains   <= '0;
		dia_ack <= 1'b0;
		repeat (4) @(posedge SYS_CLK_IN);
		arst_n <= 1'b1;
		tick();

		// Run low, nothing moves
		write_htotal(8);
		for (k = 0; k < 100; k++)
		begin
			tick();
			checks++;
			if ((dia_req !== 1'b0) || (status !== '0))
			begin
				$display("Output active with run low at %0t ns", $time);
				errors++;
			end
			sync   <= ($urandom_range(3) == 0) ? ~sync : sync;
			pix_en <= $urandom_range(1);
		end
		report_test(1, "run low idle");

		// Slow, fast, then both limits
		run <= 1'b1;
		tick();
		repeat (3)
		begin
			window_cycle(20, 2, 2);
			if (status.cur_err <= 0)
			begin
				$display("Slow video gave no positive error at %0t ns", $time);
				errors++;
			end
		end
		repeat (3)
		begin
			window_cycle(100, 5, 3);
			if (status.cur_err >= 0)
			begin
				$display("Fast video gave no negative error at %0t ns", $time);
				errors++;
			end
		end
		write_htotal(20);
		window_cycle(30, 2, 2);
		compare("status.cur_err", 31, status.cur_err);	// Upper limit
		write_htotal(1);
		window_cycle(100, 10, 3);
		compare("status.cur_err", -32, status.cur_err);
		report_test(2, "window error");

		// Words in order under random back-pressure
		write_htotal(8);
		repeat (10) window_cycle(20 + $urandom_range(80), 2, 4);
		report_test(3, "output words");

		// Integrator limits
		write_htotal(20);
		repeat (540) window_cycle(50, 1, 2);
		compare("status.sum", 16383, status.sum);
		restart_run();
		write_htotal(1);
		repeat (540) window_cycle(100, 10, 3);
		compare("status.sum", -16384, status.sum);
		report_test(4, "sum saturation");

		// Running extremes from zero
		restart_run();
		write_htotal(8);
		repeat (12) window_cycle(10 + $urandom_range(90), 2, 4);
		compare("status.max_err", m_max, status.max_err);
		compare("status.min_err", m_min, status.min_err);
		report_test(5, "error extremes");

		// Run drop with a word on offer
		gains <= 21'($urandom);
		run_window(20, 2, 2);
		cnt = 0;
		while (!dia_req && (cnt < 100))
		begin
			tick();
			cnt++;
		end
		if (!dia_req)
		begin
			$display("No output word before the run drop at %0t ns", $time);
			errors++;
		end
		run <= 1'b0;	// Word never acknowledged
		tick();
		tick();
		checks++;
		if ((dia_req !== 1'b0) || (status !== '0))
		begin
			$display("Run drop did not clear dia_req and status at %0t ns", $time);
			errors++;
		end
		clear_model();
		run <= 1'b1;
		tick();
		window_cycle(100, 5, 3);
		compare("status.sum", m_cur, status.sum);	// Fresh sum holds one error
		report_test(6, "run restart");

		$display("tests ok %0d of 6, checks %0d, errors %0d", tests_ok, checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+bench
logic/cr_pkg.sv
logic/req_ack_slot.sv
logic/phase_meter.sv
logic/pi_controller.sv
logic/clock_recovery_top.sv
bench/tb_clock_recovery.sv

// ==== Bender.yml ====
package:
  name: clock_recovery

sources:
  - logic/cr_pkg.sv
  - logic/req_ack_slot.sv
  - logic/phase_meter.sv
  - logic/pi_controller.sv
  - logic/clock_recovery_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_clock_recovery.sv
